// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_mpsoc2d
FLIST      ?= sim.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --timescale 1ns/1ps
LINT_FLAGS ?= -Wall
PASS_MSG   ?= TB PASSED

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/mpsoc2d.sv ====
`timescale 1ns/1ps

module mpsoc2d (
  input  logic                                               clk,
  input  logic                                               rst_n_i,

  input  logic [mpsoc_pkg::NODES-1:0]                        tx_valid_i,
  output logic [mpsoc_pkg::NODES-1:0]                        tx_ready_o,
  input  logic [mpsoc_pkg::NODES-1:0][mpsoc_pkg::NODE_W-1:0] tx_dest_i,
  input  logic [mpsoc_pkg::NODES-1:0][mpsoc_pkg::MSG_W-1:0]  tx_data_i,

  output logic [mpsoc_pkg::NODES-1:0]                        rx_valid_o,
  input  logic [mpsoc_pkg::NODES-1:0]                        rx_ready_i,
  output logic [mpsoc_pkg::NODES-1:0][mpsoc_pkg::NODE_W-1:0] rx_src_o,
  output logic [mpsoc_pkg::NODES-1:0][mpsoc_pkg::MSG_W-1:0]  rx_data_o
);

  import mpsoc_pkg::*;

  // flits from the tiles into the mesh, and back out.
  noc_link_if link_to_noc   [NODES] ();
  noc_link_if link_from_noc [NODES] ();

  noc_mesh2d u_noc (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .local_in  (link_to_noc),
    .local_out (link_from_noc)
  );

  generate
    for (genvar i = 0; i < NODES; i++) begin : gen_tile
      net_adapter #(
        .TILE_ID (i)
      ) u_na (
        .clk        (clk),
        .rst_n_i    (rst_n_i),

        .tx_valid_i (tx_valid_i [i]),
        .tx_ready_o (tx_ready_o [i]),
        .tx_dest_i  (tx_dest_i  [i]),
        .tx_data_i  (tx_data_i  [i]),

        .rx_valid_o (rx_valid_o [i]),
        .rx_ready_i (rx_ready_i [i]),
        .rx_src_o   (rx_src_o   [i]),
        .rx_data_o  (rx_data_o  [i]),

        .net_out    (link_to_noc   [i]),
        .net_in     (link_from_noc [i])
      );
    end
  endgenerate

endmodule

// ==== design/mpsoc_pkg.sv ====
package mpsoc_pkg;

  ////////////////////
  // mesh geometry
  ////////////////////

  localparam int MESH_X  = 2;
  localparam int MESH_Y  = 2;
  localparam int NODES   = MESH_X * MESH_Y;
  localparam int NODE_W  = (NODES > 1) ? $clog2(NODES) : 1;
  localparam int COORD_W = 2;

  ////////////////////
  // flits and messages
  ////////////////////

  localparam int FLIT_W        = 16;
  localparam int PAYLOAD_FLITS = 2;
  localparam int MSG_W         = FLIT_W * PAYLOAD_FLITS;
  localparam int FLIT_CNT_W    = $clog2(PAYLOAD_FLITS + 1);
  localparam int HDR_SRC_W     = 4;                               // enough for 16 tiles.
  localparam int HDR_RSVD_W    = FLIT_W - 2 * COORD_W - HDR_SRC_W;

  ////////////////////
  // router
  ////////////////////

  localparam int FIFO_DEPTH = 2;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam int PORTS  = 5;
  localparam int PORT_W = 3;

  localparam logic [PORT_W-1:0] PORT_LOCAL = 3'd0;
  localparam logic [PORT_W-1:0] PORT_NORTH = 3'd1;
  localparam logic [PORT_W-1:0] PORT_EAST  = 3'd2;
  localparam logic [PORT_W-1:0] PORT_SOUTH = 3'd3;               // towards larger y.
  localparam logic [PORT_W-1:0] PORT_WEST  = 3'd4;

  // the first flit of a packet is read as hdr, the rest as data.
  typedef union packed {
    struct packed {
      logic [COORD_W-1:0]    dst_x;
      logic [COORD_W-1:0]    dst_y;
      logic [HDR_SRC_W-1:0]  src;
      logic [HDR_RSVD_W-1:0] rsvd;
    } hdr;
    logic [FLIT_W-1:0] data;
  } flit_u;

endpackage

// ==== design/net_adapter.sv ====
`timescale 1ns/1ps

module net_adapter #(
  parameter int TILE_ID = 0
) (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         tx_valid_i,
  output logic                         tx_ready_o,
  input  logic [mpsoc_pkg::NODE_W-1:0] tx_dest_i,
  input  logic [mpsoc_pkg::MSG_W-1:0]  tx_data_i,
  output logic                         rx_valid_o,
  input  logic                         rx_ready_i,
  output logic [mpsoc_pkg::NODE_W-1:0] rx_src_o,
  output logic [mpsoc_pkg::MSG_W-1:0]  rx_data_o,
  noc_link_if.source                   net_out,
  noc_link_if.sink                     net_in
);

  import mpsoc_pkg::*;

  logic                  tx_busy;
  logic [FLIT_CNT_W-1:0] tx_idx;                           // 0 is the header.
  logic [COORD_W-1:0]    dst_x_q;
  logic [COORD_W-1:0]    dst_y_q;
  logic [MSG_W-1:0]      tx_data_q;
  flit_u                 tx_flit;
  logic                  tx_xfer;
  logic [FLIT_CNT_W-1:0] rx_cnt;
  logic                  rx_xfer;

  ////////////////////
  // send side
  ////////////////////

  assign tx_ready_o = !tx_busy;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      tx_busy <= 1'b0;
      tx_idx  <= '0;
    end else if (tx_valid_i && tx_ready_o) begin
      tx_busy <= 1'b1;
      tx_idx  <= '0;
    end else if (tx_xfer) begin
      tx_busy <= !net_out.last;
      tx_idx  <= tx_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tx_valid_i && tx_ready_o) begin
      dst_x_q   <= COORD_W'(int'(tx_dest_i) % MESH_X);
      dst_y_q   <= COORD_W'(int'(tx_dest_i) / MESH_X);
      tx_data_q <= tx_data_i;
    end else if (tx_xfer && (tx_idx != '0)) begin
      tx_data_q <= tx_data_q >> FLIT_W;                     // next word moves to the bottom.
    end
  end

  always_comb begin
    tx_flit = '0;
    if (tx_idx == '0) begin
      tx_flit.hdr.dst_x = dst_x_q;
      tx_flit.hdr.dst_y = dst_y_q;
      tx_flit.hdr.src   = HDR_SRC_W'(TILE_ID);
    end else begin
      tx_flit.data = tx_data_q[FLIT_W-1:0];
    end
  end

  assign net_out.flit  = tx_flit;
  assign net_out.last  = (tx_idx == FLIT_CNT_W'(PAYLOAD_FLITS));
  assign net_out.valid = tx_busy;
  assign tx_xfer       = net_out.valid && net_out.ready;

  ////////////////////
  // receive side
  ////////////////////

  assign net_in.ready = !rx_valid_o;                       // stall while a message waits.
  assign rx_xfer      = net_in.valid && net_in.ready;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rx_cnt     <= '0;
      rx_valid_o <= 1'b0;
    end else if (rx_xfer) begin
      rx_cnt     <= net_in.last ? '0 : rx_cnt + 1'b1;
      rx_valid_o <= net_in.last;
    end else if (rx_ready_i) begin
      rx_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_xfer) begin
      if (rx_cnt == '0) begin
        rx_src_o <= net_in.flit.hdr.src[NODE_W-1:0];
      end else begin
        rx_data_o <= {net_in.flit.data, rx_data_o[MSG_W-1:FLIT_W]};   // first word ends low.
      end
    end
  end

endmodule

// ==== design/noc_link_if.sv ====
`timescale 1ns/1ps

interface noc_link_if;

  import mpsoc_pkg::*;

  flit_u flit;
  logic  last;
  logic  valid;
  logic  ready;

  modport source (
    output flit, last, valid,
    input  ready
  );

  modport sink (
    input  flit, last, valid,
    output ready
  );

endinterface

// ==== design/noc_mesh2d.sv ====
`timescale 1ns/1ps

module noc_mesh2d (
  input  logic       clk,
  input  logic       rst_n_i,
  noc_link_if.sink   local_in  [mpsoc_pkg::NODES],
  noc_link_if.source local_out [mpsoc_pkg::NODES]
);

  import mpsoc_pkg::*;

  // outputs of every router, and the ready of every router input.
  flit_u            lnk_flit  [MESH_Y][MESH_X][PORTS];
  logic [PORTS-1:0] lnk_last  [MESH_Y][MESH_X];
  logic [PORTS-1:0] lnk_valid [MESH_Y][MESH_X];
  logic [PORTS-1:0] lnk_rdy   [MESH_Y][MESH_X];

  for (genvar y = 0; y < MESH_Y; y++) begin : gen_y
    for (genvar x = 0; x < MESH_X; x++) begin : gen_x
      noc_link_if rin  [PORTS] ();
      noc_link_if rout [PORTS] ();

      noc_router #(
        .X_POS (x),
        .Y_POS (y)
      ) u_router (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .in_link  (rin),
        .out_link (rout)
      );

      for (genvar p = 0; p < PORTS; p++) begin : gen_exp
        assign lnk_flit[y][x][p]  = rout[p].flit;
        assign lnk_last[y][x][p]  = rout[p].last;
        assign lnk_valid[y][x][p] = rout[p].valid;
        assign lnk_rdy[y][x][p]   = rin[p].ready;
      end

      assign rin[PORT_LOCAL].flit          = local_in[y*MESH_X+x].flit;
      assign rin[PORT_LOCAL].last          = local_in[y*MESH_X+x].last;
      assign rin[PORT_LOCAL].valid         = local_in[y*MESH_X+x].valid;
      assign local_in[y*MESH_X+x].ready    = lnk_rdy[y][x][PORT_LOCAL];
      assign local_out[y*MESH_X+x].flit    = lnk_flit[y][x][PORT_LOCAL];
      assign local_out[y*MESH_X+x].last    = lnk_last[y][x][PORT_LOCAL];
      assign local_out[y*MESH_X+x].valid   = lnk_valid[y][x][PORT_LOCAL];
      assign rout[PORT_LOCAL].ready        = local_out[y*MESH_X+x].ready;

      // each compass input takes the facing output of its neighbour.
      for (genvar p = 1; p < PORTS; p++) begin : gen_dir
        if (p == PORT_NORTH && y > 0) begin : gen_n
          assign rin[p].flit   = lnk_flit[y-1][x][PORT_SOUTH];
          assign rin[p].last   = lnk_last[y-1][x][PORT_SOUTH];
          assign rin[p].valid  = lnk_valid[y-1][x][PORT_SOUTH];
          assign rout[p].ready = lnk_rdy[y-1][x][PORT_SOUTH];
        end else if (p == PORT_EAST && x < MESH_X - 1) begin : gen_e
          assign rin[p].flit   = lnk_flit[y][x+1][PORT_WEST];
          assign rin[p].last   = lnk_last[y][x+1][PORT_WEST];
          assign rin[p].valid  = lnk_valid[y][x+1][PORT_WEST];
          assign rout[p].ready = lnk_rdy[y][x+1][PORT_WEST];
        end else if (p == PORT_SOUTH && y < MESH_Y - 1) begin : gen_s
          assign rin[p].flit   = lnk_flit[y+1][x][PORT_NORTH];
          assign rin[p].last   = lnk_last[y+1][x][PORT_NORTH];
          assign rin[p].valid  = lnk_valid[y+1][x][PORT_NORTH];
          assign rout[p].ready = lnk_rdy[y+1][x][PORT_NORTH];
        end else if (p == PORT_WEST && x > 0) begin : gen_w
          assign rin[p].flit   = lnk_flit[y][x-1][PORT_EAST];
          assign rin[p].last   = lnk_last[y][x-1][PORT_EAST];
          assign rin[p].valid  = lnk_valid[y][x-1][PORT_EAST];
          assign rout[p].ready = lnk_rdy[y][x-1][PORT_EAST];
        end else begin : gen_edge
          assign rin[p].flit   = '0;                       // nothing arrives from the edge.
          assign rin[p].last   = 1'b0;
          assign rin[p].valid  = 1'b0;
          assign rout[p].ready = 1'b1;
        end
      end
    end
  end

endmodule

// ==== design/noc_router.sv ====
`timescale 1ns/1ps

module noc_router #(
  parameter int X_POS = 0,
  parameter int Y_POS = 0
) (
  input  logic       clk,
  input  logic       rst_n_i,
  noc_link_if.sink   in_link  [mpsoc_pkg::PORTS],
  noc_link_if.source out_link [mpsoc_pkg::PORTS]
);

  import mpsoc_pkg::*;

  flit_u             head_flit [PORTS];
  logic [PORTS-1:0]  head_last;
  logic [PORTS-1:0]  head_vld;
  logic [PORT_W-1:0] route     [PORTS];
  logic [PORT_W-1:0] grant_idx [PORTS];
  logic [PORTS-1:0]  out_xfer;

  ////////////////////
  // input buffers
  ////////////////////

  for (genvar p = 0; p < PORTS; p++) begin : gen_in
    flit_u                 mem [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0] mem_last;
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  push;
    logic                  pop;
    logic                  in_pkt;                         // head is a payload flit.
    logic [PORT_W-1:0]     route_q;
    logic [PORT_W-1:0]     route_hdr;

    assign in_link[p].ready = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign push             = in_link[p].valid && in_link[p].ready;

    assign head_vld[p]  = (count != '0);
    assign head_flit[p] = mem[rd_ptr];
    assign head_last[p] = mem_last[rd_ptr];

    always_ff @(posedge clk) begin
      if (push) begin
        mem[wr_ptr]      <= in_link[p].flit;
        mem_last[wr_ptr] <= in_link[p].last;
      end
    end

    always_ff @(posedge clk) begin
      if (!rst_n_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
        in_pkt <= 1'b0;
      end else begin
        if (push) begin
          wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
          in_pkt <= !head_last[p];
        end
        if (push && !pop) begin
          count <= count + 1'b1;
        end else if (!push && pop) begin
          count <= count - 1'b1;
        end
      end
    end

    // xy routing, x is resolved first.
    always_comb begin
      if (int'(head_flit[p].hdr.dst_x) > X_POS) begin
        route_hdr = PORT_EAST;
      end else if (int'(head_flit[p].hdr.dst_x) < X_POS) begin
        route_hdr = PORT_WEST;
      end else if (int'(head_flit[p].hdr.dst_y) > Y_POS) begin
        route_hdr = PORT_SOUTH;
      end else if (int'(head_flit[p].hdr.dst_y) < Y_POS) begin
        route_hdr = PORT_NORTH;
      end else begin
        route_hdr = PORT_LOCAL;
      end
    end

    always_ff @(posedge clk) begin
      if (pop && !in_pkt) begin
        route_q <= route_hdr;                              // body flits follow the header.
      end
    end

    assign route[p] = in_pkt ? route_q : route_hdr;

    always_comb begin
      pop = 1'b0;
      for (int o = 0; o < PORTS; o++) begin
        if (out_xfer[o] && (grant_idx[o] == PORT_W'(p))) begin
          pop = 1'b1;
        end
      end
    end
  end

  ////////////////////
  // output arbiters
  ////////////////////

  for (genvar o = 0; o < PORTS; o++) begin : gen_out
    logic [PORTS-1:0]  req;
    logic              lock_q;
    logic [PORT_W-1:0] owner_q;
    logic [PORT_W-1:0] prio_q;
    logic [PORT_W-1:0] rr_idx;
    logic              rr_vld;

    always_comb begin
      for (int i = 0; i < PORTS; i++) begin
        req[i] = head_vld[i] && (route[i] == PORT_W'(o));
      end
    end

    always_comb begin : rr_pick
      int cand;
      cand   = 0;
      rr_vld = 1'b0;
      rr_idx = prio_q;
      for (int k = PORTS - 1; k >= 0; k--) begin          // lowest k wins, it is written last.
        cand = int'(prio_q) + k;
        if (cand >= PORTS) begin
          cand = cand - PORTS;
        end
        if (req[cand]) begin
          rr_vld = 1'b1;
          rr_idx = PORT_W'(cand);
        end
      end
    end

    assign grant_idx[o]      = lock_q ? owner_q : rr_idx;
    assign out_link[o].valid = lock_q ? req[owner_q] : rr_vld;
    assign out_link[o].flit  = head_flit[grant_idx[o]];
    assign out_link[o].last  = head_last[grant_idx[o]];
    assign out_xfer[o]       = out_link[o].valid && out_link[o].ready;

    always_ff @(posedge clk) begin
      if (!rst_n_i) begin
        lock_q  <= 1'b0;
        owner_q <= '0;
        prio_q  <= '0;
      end else if (out_xfer[o]) begin
        if (head_last[grant_idx[o]]) begin
          lock_q <= 1'b0;
          prio_q <= (grant_idx[o] == PORT_W'(PORTS - 1)) ? '0 : grant_idx[o] + 1'b1;
        end else begin
          lock_q  <= 1'b1;                                 // hold the output until the tail.
          owner_q <= grant_idx[o];
        end
      end
    end
  end

endmodule

// ==== sim.f ====
design/mpsoc_pkg.sv
design/noc_link_if.sv
design/noc_router.sv
design/noc_mesh2d.sv
design/net_adapter.sv
design/mpsoc2d.sv
test/tb_clock_gen.sv
test/tb_mpsoc2d.sv

// ==== test/mpsoc_testdata.txt ====
// columns: source tile, destination tile, payload word 0, payload word 1 (hex)
// a line of ffff ends the list
0 1 0101 a001
1 0 1000 a002
2 3 2303 a003
3 2 3202 a004
0 2 0202 a005
1 3 1303 a006
3 0 3000 a007
2 1 2101 a008
0 0 0000 b001
1 1 1111 b002
3 3 3333 b003
2 2 2222 b004
0 3 c001 0d01
0 3 c002 0d02
0 3 c003 0d03
0 3 c004 0d04
0 3 c005 0d05
0 2 e001 f000
1 2 e002 f001
2 2 e003 f002
3 2 e004 f003
0 2 e005 f004
1 2 e006 f005
3 2 e007 f006
ffff ffff ffff ffff

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 4,
  parameter int RST_DLY    = 1
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #RST_DLY;
    rst_n_o = 1'b1;                                        // released just after an edge.
  end

endmodule

// ==== test/tb_mpsoc2d.sv ====
`timescale 1ns/1ps

module tb_mpsoc2d;

  import mpsoc_pkg::*;

  localparam int    PERIOD_NS    = 40;
  localparam int    DRIVE_DLY    = 1;
  localparam int    MAX_MSGS     = 64;
  localparam int    WD_PER_MSG   = 200;
  localparam int    WD_EXTRA     = 1000;
  localparam int    DRAIN_CYCLES = 20;
  localparam string DATA_FILE    = "test/mpsoc_testdata.txt";

  logic                           clk;
  logic                           rst_n;
  wire  [NODES-1:0]               tx_valid;
  logic [NODES-1:0]               tx_ready;
  wire  [NODES-1:0][NODE_W-1:0]   tx_dest;
  wire  [NODES-1:0][MSG_W-1:0]    tx_data;
  logic [NODES-1:0]               rx_valid;
  logic [NODES-1:0]               rx_ready = '0;
  logic [NODES-1:0][NODE_W-1:0]   rx_src;
  logic [NODES-1:0][MSG_W-1:0]    rx_data;

  logic [15:0]       tdata    [MAX_MSGS*4+4];              // src, dst, word 0, word 1.
  logic [NODE_W-1:0] msg_src  [MAX_MSGS];
  logic [NODE_W-1:0] msg_dst  [MAX_MSGS];
  logic [MSG_W-1:0]  msg_data [MAX_MSGS];
  logic [MSG_W-1:0]  exp_q    [NODES][NODES][$];           // one queue per src and dst pair.

  int     n_msgs    = 0;
  int     n_rcvd    = 0;
  int     err_count = 0;
  logic   loaded    = 1'b0;
  logic   stim_go   = 1'b0;
  integer seed      = 32'hac9c1bb1;

  tb_clock_gen #(
    .PERIOD_NS  (PERIOD_NS),
    .RST_CYCLES (4),
    .RST_DLY    (DRIVE_DLY)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mpsoc2d u_dut (
    .clk        (clk),
    .rst_n_i    (rst_n),
    .tx_valid_i (tx_valid),
    .tx_ready_o (tx_ready),
    .tx_dest_i  (tx_dest),
    .tx_data_i  (tx_data),
    .rx_valid_o (rx_valid),
    .rx_ready_i (rx_ready),
    .rx_src_o   (rx_src),
    .rx_data_o  (rx_data)
  );

  ////////////////////
  // senders
  ////////////////////

  for (genvar t = 0; t < NODES; t++) begin : gen_send
    logic              snd_valid = 1'b0;
    logic [NODE_W-1:0] snd_dest  = '0;
    logic [MSG_W-1:0]  snd_data  = '0;

    assign tx_valid[t] = snd_valid;
    assign tx_dest[t]  = snd_dest;
    assign tx_data[t]  = snd_data;

    initial begin : drive
      logic taken;
      wait (stim_go);
      for (int k = 0; k < n_msgs; k++) begin
        if (msg_src[k] == NODE_W'(t)) begin
          snd_dest  = msg_dst[k];
          snd_data  = msg_data[k];
          snd_valid = 1'b1;
          do begin
            taken = tx_ready[t];                           // tx_ready_o only changes on the edge.
            @(posedge clk);
            #DRIVE_DLY;
          end while (!taken);
          snd_valid = 1'b0;
        end
      end
    end
  end

  // random back-pressure on every receiving tile.
  always @(posedge clk) begin
    if (stim_go) begin
      #DRIVE_DLY;
      for (int t = 0; t < NODES; t++) begin
        rx_ready[t] = (($random(seed) & 3) != 0);
      end
    end
  end

  ////////////////////
  // checking
  ////////////////////

  task automatic check_delivery(input int tile);
    logic [NODE_W-1:0] src;
    int                exp_src;
    logic [MSG_W-1:0]  exp_data;
    src     = rx_src[tile];
    exp_src = -1;
    n_rcvd  = n_rcvd + 1;
    if (exp_q[src][tile].size() != 0 && exp_q[src][tile][0] === rx_data[tile]) begin
      exp_src = int'(src);
    end
    // otherwise the sender is the tile whose oldest message to here has this data.
    for (int s = 0; s < NODES; s++) begin
      if (exp_src < 0 && exp_q[s][tile].size() != 0 && exp_q[s][tile][0] === rx_data[tile]) begin
        exp_src = s;
      end
    end
    if (exp_src >= 0) begin
      exp_data = exp_q[exp_src][tile].pop_front();
      if (int'(src) != exp_src) begin
        err_count = err_count + 1;
        $display("FAILED %0t rx_src_o[%0d] expected %0d actual %0d",
                 $time, tile, exp_src, src);
      end
    end else if (exp_q[src][tile].size() != 0) begin
      exp_data  = exp_q[src][tile].pop_front();
      err_count = err_count + 1;
      $display("FAILED %0t rx_data_o[%0d] expected %h actual %h",
               $time, tile, exp_data, rx_data[tile]);
    end else begin
      err_count = err_count + 1;
      $display("at %0t tile %0d got a message from tile %0d that was not expected there",
               $time, tile, src);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      for (int t = 0; t < NODES; t++) begin
        if (rx_valid[t] && rx_ready[t]) begin
          check_delivery(t);
        end
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (n_msgs * WD_PER_MSG + WD_EXTRA) @(posedge clk);
    $display("timeout, only %0d of %0d messages arrived", n_rcvd, n_msgs);
    $display("TB FAILED");
    $finish;
  end

  initial begin : main
    logic [NODE_W-1:0] s;
    logic [NODE_W-1:0] d;
    tdata[0] = 16'hffff;
    $readmemh(DATA_FILE, tdata);
    while (n_msgs < MAX_MSGS && tdata[4*n_msgs] != 16'hffff) begin
      s                = NODE_W'(tdata[4*n_msgs]);
      d                = NODE_W'(tdata[4*n_msgs+1]);
      msg_src[n_msgs]  = s;
      msg_dst[n_msgs]  = d;
      msg_data[n_msgs] = {tdata[4*n_msgs+3], tdata[4*n_msgs+2]};   // word 0 sits low.
      exp_q[s][d].push_back(msg_data[n_msgs]);
      n_msgs = n_msgs + 1;
    end
    loaded = 1'b1;
    if (n_msgs == 0) begin
      err_count = err_count + 1;
      $display("no messages were read from %s", DATA_FILE);
    end

    wait (rst_n);
    @(posedge clk);
    #DRIVE_DLY;
    if (tx_ready !== {NODES{1'b1}}) begin
      err_count = err_count + 1;
      $display("FAILED %0t tx_ready_o expected %b actual %b", $time, {NODES{1'b1}}, tx_ready);
    end
    if (rx_valid !== '0) begin
      err_count = err_count + 1;
      $display("FAILED %0t rx_valid_o expected %b actual %b", $time, {NODES{1'b0}}, rx_valid);
    end
    stim_go = 1'b1;

    wait (n_rcvd >= n_msgs);
    repeat (DRAIN_CYCLES) @(posedge clk);                  // catches late duplicates.
    for (int i = 0; i < NODES; i++) begin
      for (int j = 0; j < NODES; j++) begin
        if (exp_q[i][j].size() != 0) begin
          err_count = err_count + 1;
          $display("%0d message(s) from tile %0d to tile %0d never arrived",
                   exp_q[i][j].size(), i, j);
        end
      end
    end
    $display("errors: %0d, messages received: %0d of %0d", err_count, n_rcvd, n_msgs);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
